/* dv/foosball_tb.sv */
`timescale 1ns/1ps

module foosball_tb;

   import game_cfg_pkg::*;
   import game_types_pkg::*;

   localparam int refresh_tb = 9;         // tick every 10 clocks
   localparam int tick_len   = refresh_tb + 1;

   // rough length of each test in clocks, the run limit is twice the sum
   localparam int len_picture = 160;
   localparam int len_motion  = 8 * tick_len;
   localparam int len_limits  = 47 * tick_len;
   localparam int len_goal    = 240 * tick_len;
   localparam int len_reverse = 315 * tick_len;
   localparam int cycle_limit = 2 * (len_picture + len_motion + len_limits
                                     + len_goal + len_reverse);

   logic     clk;
   logic     reset;
   logic     stop_ball;
   rod_btn_t left_btn, right_btn;
   pixel_t   pix;
   rgb_t     rgb;
   logic     score1, score2;

   int errors, checks, tests_run, tests_failed, cycles, overlaps;

   // reference model state
   int m_cnt, m_ltop, m_rtop, m_bx, m_by, m_vh, m_vv, m_goals1, m_goals2;
   bit m_serve_left, m_ticked, exp_s1, exp_s2;

   tb_clock #(.period_ns(4)) u_clk (.clk(clk));

   foosball_top #(.refresh_period(refresh_tb)) uut (
      .clk(clk), .reset(reset), .stop_ball(stop_ball),
      .left_btn(left_btn), .right_btn(right_btn),
      .pix(pix), .rgb(rgb), .score1(score1), .score2(score2)
   );

   ////////////////////////////////////////
   // reference rules
   ////////////////////////////////////////

   function automatic int rod_next(int top, rod_btn_t b);
      if (b.up && top > rod_step)
         return top - rod_step;            // up wins over down
      if (b.down && top < field_bottom - rod_step - rod_len)
         return top + rod_step;
      return top;
   endfunction

   function automatic bit on_frame(int x, int y);
      return (y < 5) || (y > 474)
             || ((y != 0) && ((y < goal_low) || (y > goal_high)) && ((x < 5) || (x > 634)));
   endfunction

   function automatic bit on_rod(int x, int y, int top, int rx);
      return (y > top) && (y < top + rod_len) && (x > rx) && (x < rx + rod_thick);
   endfunction

   function automatic bit on_ball(int x, int y);
      return (x - m_bx) * (x - m_bx) + (y - m_by) * (y - m_by) <= ball_radius * ball_radius;
   endfunction

   function automatic int cover_count(int x, int y);
      return int'(on_frame(x, y)) + int'(on_rod(x, y, m_ltop, left_rod_x))
             + int'(on_rod(x, y, m_rtop, right_rod_x)) + int'(on_ball(x, y));
   endfunction

   function automatic rgb_t exp_colour(int x, int y, bit vo);
      if (!vo)
         return col_blank;
      if (cover_count(x, y) == 0)
         return col_field;
      if (cover_count(x, y) > 1)
         return col_blank;                 // overlap is black
      if (on_frame(x, y))
         return col_frame;
      if (on_rod(x, y, m_ltop, left_rod_x))
         return col_left_rod;
      if (on_rod(x, y, m_rtop, right_rod_x))
         return col_right_rod;
      return col_ball;
   endfunction

   // model steps on every edge, with the inputs as they stand before it
   always @(posedge clk or posedge reset)
   begin : model_step
      int  nbx, nby, nvh, nvv;
      bit  tick, gr, gl, mouth, off_gap;
      if (reset)
      begin
         m_cnt = 0;
         m_ltop = rod_start_top;
         m_rtop = rod_start_top;
         m_bx = ball_start;
         m_by = ball_start;
         m_vh = 0;
         m_vv = 0;
         m_serve_left = 0;
         m_ticked = 0;
         exp_s1 = 0;
         exp_s2 = 0;
      end
      else
      begin
         tick = (m_cnt == 0);
         m_cnt = (m_cnt == refresh_tb) ? 0 : m_cnt + 1;
         gr = 0;
         gl = 0;
         nbx = m_bx;
         nby = m_by;
         nvh = m_vh;
         nvv = m_vv;
         if (tick)
         begin
            mouth = (m_by >= goal_low) && (m_by <= goal_high);
            gr = mouth && (m_bx >= 637);
            gl = mouth && (m_bx <= 3);
            if (m_by >= m_rtop && m_by <= m_rtop + rod_len
                && m_bx >= right_rod_x - 3 && m_bx <= right_rod_x + 5)
               nvh = -ball_speed;
            else if (m_by >= m_ltop && m_by <= m_ltop + rod_len
                     && m_bx >= left_rod_x + 7 && m_bx <= left_rod_x + 12)
               nvh = ball_speed;
            off_gap = (m_by < wall_gap_low) || (m_by > wall_gap_high);
            if (m_by < top_bounce)
               nvv = ball_speed;
            else if (m_by > bottom_bounce)
               nvv = -ball_speed;
            else if (m_bx >= 630 && off_gap)
               nvh = -ball_speed;
            else if (m_bx <= 3 && off_gap)
               nvh = ball_speed;
            nbx = m_bx + m_vh;             // old velocity moves the ball
            nby = m_by + m_vv;
            if (gr || gl)
            begin
               nbx = ball_start;
               nby = ball_start;
               nvh = 0;
               nvv = 0;
            end
            m_ltop = rod_next(m_ltop, left_btn);
            m_rtop = rod_next(m_rtop, right_btn);
         end
         if (stop_ball)
         begin
            nvh = m_serve_left ? -serve_h : serve_h;
            nvv = m_serve_left ? -serve_v : serve_v;
         end
         if (gr)
            m_serve_left = 0;
         else if (gl)
            m_serve_left = 1;
         m_bx = nbx;
         m_by = nby;
         m_vh = nvh;
         m_vv = nvv;
         exp_s1 = gr;                      // pulse one clock after the tick
         exp_s2 = gl;
         m_goals1 += int'(gr);
         m_goals2 += int'(gl);
         m_ticked = tick;
      end
   end

   ////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////

   task automatic check_rgb(rgb_t got, rgb_t exp, string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[ERROR] %0t ns: %s rgb %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_top(coord_t got, coord_t exp, string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_score(logic s1, logic s2, logic e1, logic e2);
      checks++;
      if (s1 !== e1 || s2 !== e2)
      begin
         errors++;
         $display("[ERROR] %0t ns: scores %b%b, expected %b%b", $time, s1, s2, e1, e2);
      end
   endtask

   // score pulses are compared on every clock
   always @(posedge clk)
   begin
      #1;
      if (!reset)
         check_score(score1, score2, exp_s1, exp_s2);
   end

   always @(posedge clk) cycles++;

   initial
   begin
      wait (cycles >= cycle_limit);
      $display("timeout: the run did not finish within %0d clocks", cycle_limit);
      $display("TEST FAIL");
      $finish;
   end

   ////////////////////////////////////////
   // drive helpers
   ////////////////////////////////////////

   task automatic step();
      @(posedge clk);
      #1;                                  // inputs move just after the edge
   endtask

   task automatic wait_tick();
      step();
      while (!m_ticked)
         step();
   endtask

   task automatic apply_reset();
      step();
      reset = 1'b1;
      step();
      step();
      reset = 1'b0;
   endtask

   // drive one pixel and check its colour one clock later
   task automatic probe_pixel(int x, int y, bit vo, string what);
      rgb_t exp;
      if (x < 0 || x > 639 || y < 0 || y > 479)
         return;
      pix = '{x: x[9:0], y: y[8:0], video_on: vo};
      exp = exp_colour(x, y, vo);
      if (vo && cover_count(x, y) > 1)
         overlaps++;
      step();
      check_rgb(rgb, exp, what);
   endtask

   task automatic probe_ball();
      probe_pixel(m_bx, m_by, 1, "ball centre");
      probe_pixel(m_bx + 4, m_by, 1, "ball body");
      probe_pixel(m_bx + 8, m_by, 1, "ball rim");
      probe_pixel(m_bx + 9, m_by, 1, "beside ball");
   endtask

   // ball colour where the serve rules put the ball centre
   task automatic expect_ball_at(int x, int y, string what);
      probe_pixel(x, y, 1, what);
      check_rgb(rgb, col_ball, what);
   endtask

   // scan rows around the expected top, first rod row lies just below the top
   task automatic measure_top(int x, int exp_top, rgb_t col, output int top);
      top = -1;
      for (int y = exp_top - 3; y <= exp_top + 3; y++)
      begin
         pix = '{x: x[9:0], y: y[8:0], video_on: 1'b1};
         step();
         if (rgb === col && top < 0)
            top = y - 1;
      end
   endtask

   task automatic serve_once();
      wait_tick();
      stop_ball = 1'b1;
      step();
      stop_ball = 1'b0;
   endtask

   task automatic report(string name, int err_before);
      tests_run++;
      if (errors == err_before)
         $display("%s: passed", name);
      else
      begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, errors - err_before);
      end
   endtask

   // follow the ball tick by tick until the model sees a goal
   task automatic run_to_goal(bit steer);
      int  g;
      bit  holding;
      g = m_goals1 + m_goals2;
      holding = 0;
      for (int t = 0; t < 400; t++)
      begin
         wait_tick();
         if (m_goals1 + m_goals2 != g)
            return;
         if (steer && !holding && m_vh < 0 && m_bx <= 400)
         begin
            holding = 1;                   // keep serving to pass the right wall
            stop_ball = 1'b1;
         end
         else if (steer && holding && m_bx >= 637)
            stop_ball = 1'b0;              // ball is in the mouth, let it score
         probe_ball();
      end
      errors++;
      $display("no goal came within 400 ticks");
   endtask

   ////////////////////////////////////////
   // tests
   ////////////////////////////////////////

   task automatic test_reset_picture();
      int e;
      e = errors;
      apply_reset();
      probe_pixel(300, 300, 1, "ball at start");
      check_rgb(rgb, col_ball, "ball colour");
      probe_pixel(10, 300, 1, "left rod");
      check_rgb(rgb, col_left_rod, "left rod colour");
      probe_pixel(630, 300, 1, "right rod");
      check_rgb(rgb, col_right_rod, "right rod colour");
      probe_pixel(100, 2, 1, "frame");
      check_rgb(rgb, col_frame, "frame colour");
      probe_pixel(320, 100, 1, "field");
      check_rgb(rgb, col_field, "field colour");
      probe_pixel(300, 300, 0, "blanking")        ;
      check_rgb(rgb, col_blank, "blank colour");
      // rgb keeps the old colour until the edge after the cursor moves
      pix = '{x: 10'd300, y: 9'd300, video_on: 1'b1};
      #1;
      check_rgb(rgb, col_blank, "rgb before the edge");
      step();
      check_rgb(rgb, col_ball, "rgb one clock later");
      for (int i = 0; i < 150; i++)
         probe_pixel($urandom % 640, $urandom % 480, ($urandom % 4) != 0, "random pixel");
      report("reset picture", e);
   endtask

   task automatic test_rod_motion();
      int e, top;
      e = errors;
      left_btn = '{up: 1'b1, down: 1'b0};
      right_btn = '{up: 1'b0, down: 1'b1};
      repeat (5) wait_tick();
      left_btn = '0;
      right_btn = '0;
      measure_top(10, 210, col_left_rod, top);
      check_top(coord_t'(top), coord_t'(210), "left rod top");
      measure_top(630, 310, col_right_rod, top);
      check_top(coord_t'(top), coord_t'(310), "right rod top");
      report("rod motion", e);
   endtask

   task automatic test_rod_limits();
      int e, top, exp_l, exp_r;
      e = errors;
      exp_l = m_ltop;
      exp_r = m_rtop;
      left_btn = '{up: 1'b1, down: 1'b0};
      right_btn = '{up: 1'b0, down: 1'b1};
      for (int i = 0; i < 40; i++)
      begin
         exp_l = rod_next(exp_l, left_btn);
         exp_r = rod_next(exp_r, right_btn);
         wait_tick();
      end
      left_btn = '0;
      right_btn = '{up: 1'b1, down: 1'b1};  // both held, up wins
      for (int i = 0; i < 3; i++)
      begin
         exp_r = rod_next(exp_r, right_btn);
         wait_tick();
      end
      right_btn = '0;
      measure_top(10, exp_l, col_left_rod, top);
      check_top(coord_t'(top), coord_t'(exp_l), "left rod at limit");
      measure_top(630, exp_r, col_right_rod, top);
      check_top(coord_t'(top), coord_t'(exp_r), "right rod after both buttons");
      report("rod limits", e);
   endtask

   task automatic test_serve_goal();
      int e;
      e = errors;
      apply_reset();
      m_goals1 = 0;
      m_goals2 = 0;
      overlaps = 0;
      left_btn = '{up: 1'b1, down: 1'b0};    // rods up, out of the ball path
      right_btn = '{up: 1'b1, down: 1'b0};
      serve_once();
      repeat (3) wait_tick();
      expect_ball_at(312, 309, "served ball");
      probe_ball();
      run_to_goal(1);
      if (m_goals1 != 1 || m_goals2 != 0)
      begin
         errors++;
         $display("the model saw %0d right and %0d left goals, expected one right goal",
                  m_goals1, m_goals2);
      end
      if (overlaps == 0)
      begin
         errors++;
         $display("no pixel with two objects was probed");
      end
      probe_ball();                        // ball waits at the centre spot
      expect_ball_at(ball_start, ball_start, "ball after goal");
      report("serve and goal", e);
   endtask

   task automatic test_reversed_serve();
      int e;
      e = errors;
      serve_once();
      repeat (3) wait_tick();
      expect_ball_at(312, 309, "second serve");
      probe_ball();
      run_to_goal(0);
      if (m_goals2 != 1)
      begin
         errors++;
         $display("the ball did not reach the left goal");
      end
      serve_once();
      repeat (3) wait_tick();
      expect_ball_at(288, 291, "left serve");
      probe_ball();
      report("reversed serve", e);
   endtask

   initial
   begin
      reset = 1'b1;
      stop_ball = 1'b0;
      left_btn = '0;
      right_btn = '0;
      pix = '0;
      errors = 0;
      checks = 0;
      tests_run = 0;
      tests_failed = 0;
      cycles = 0;
      void'($urandom(6));                  // fixed seed for the pixel picks
      test_reset_picture();
      test_rod_motion();
      test_rod_limits();
      test_serve_goal();
      test_reversed_serve();
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0 && tests_failed == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
   parameter int period_ns = 4            // full clock period
) (
   output logic clk
);

   initial
   begin
      clk = 1'b0;
   end

   always #(period_ns / 2) clk = ~clk;    // free running, 50% duty

endmodule

/* foosball.f */
hw/game_cfg_pkg.sv
hw/game_types_pkg.sv
hw/game_ctrl.sv
hw/rod_mover.sv
hw/ball_mover.sv
hw/pixel_renderer.sv
hw/foosball_top.sv
dv/tb_clock.sv
dv/foosball_tb.sv

/* hw/ball_mover.sv */
`timescale 1ns/1ps

module ball_mover (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   frame_tick,
   input  logic                   serve,        // throw level
   input  logic                   serve_left,   // throw toward player 1
   input  game_types_pkg::coord_t left_top,
   input  game_types_pkg::coord_t right_top,
   output game_types_pkg::ball_t  ball,
   output logic                   goal_right_mouth,
   output logic                   goal_left_mouth
);

   import game_cfg_pkg::*;
   import game_types_pkg::*;

   // x windows where a rod face catches the ball
   localparam int right_hit_lo = right_rod_x - 3;
   localparam int right_hit_hi = right_rod_x + 5;
   localparam int left_hit_lo  = left_rod_x + 7;
   localparam int left_hit_hi  = left_rod_x + 12;

   localparam int wall_right = 630;       // side wall columns
   localparam int wall_left  = 3;
   localparam int goal_right = 637;       // ball past these is in a goal
   localparam int goal_left  = 3;

   vel_t  vel_h, vel_v;                   // current velocity
   vel_t  vel_h_next, vel_v_next;
   ball_t ball_next;

   logic hit_right, hit_left;
   logic off_gap;                         // row lies on a solid side wall
   logic in_mouth;                        // row lies inside a goal mouth

   ////////////////////////////////////////
   // position tests
   ////////////////////////////////////////

   assign hit_right = (ball.y >= right_top) && (ball.y <= right_top + rod_len)
                      && (ball.x >= right_hit_lo) && (ball.x <= right_hit_hi);
   assign hit_left  = (ball.y >= left_top) && (ball.y <= left_top + rod_len)
                      && (ball.x >= left_hit_lo) && (ball.x <= left_hit_hi);

   assign off_gap  = (ball.y < wall_gap_low) || (ball.y > wall_gap_high);
   assign in_mouth = (ball.y >= goal_low) && (ball.y <= goal_high);

   // strobes only in a tick cycle
   assign goal_right_mouth = frame_tick && in_mouth && (ball.x >= goal_right);
   assign goal_left_mouth  = frame_tick && in_mouth && (ball.x <= goal_left);

   ////////////////////////////////////////
   // next state
   ////////////////////////////////////////

   always_comb
   begin
      ball_next  = ball;
      vel_h_next = vel_h;
      vel_v_next = vel_v;
      if (frame_tick)
      begin
         // rod faces, right rod first
         if (hit_right)
            vel_h_next = vel_t'(-ball_speed);
         else if (hit_left)
            vel_h_next = vel_t'(ball_speed);

         // walls override the rods
         if (ball.y < top_bounce)
            vel_v_next = vel_t'(ball_speed);
         else if (ball.y > bottom_bounce)
            vel_v_next = vel_t'(-ball_speed);
         else if ((ball.x >= wall_right) && off_gap)
            vel_h_next = vel_t'(-ball_speed);
         else if ((ball.x <= wall_left) && off_gap)
            vel_h_next = vel_t'(ball_speed);

         ball_next.x = ball.x + coord_t'(vel_h);   // move with the old velocity
         ball_next.y = ball.y + coord_t'(vel_v);

         if (goal_right_mouth || goal_left_mouth)
         begin
            ball_next.x = coord_t'(ball_start);    // back to the centre spot
            ball_next.y = coord_t'(ball_start);
            vel_h_next  = '0;                      // and wait for a serve
            vel_v_next  = '0;
         end
      end
      if (serve)                          // throw beats anything from the tick
      begin
         vel_h_next = serve_left ? vel_t'(-serve_h) : vel_t'(serve_h);
         vel_v_next = serve_left ? vel_t'(-serve_v) : vel_t'(serve_v);
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         ball.x <= coord_t'(ball_start);
         ball.y <= coord_t'(ball_start);
         vel_h  <= '0;
         vel_v  <= '0;
      end
      else
      begin
         ball  <= ball_next;
         vel_h <= vel_h_next;
         vel_v <= vel_v_next;
      end
   end

endmodule

/* hw/foosball_top.sv */
`timescale 1ns/1ps

module foosball_top #(
   parameter int refresh_period = game_cfg_pkg::refresh_default
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     stop_ball,
   input  game_types_pkg::rod_btn_t left_btn,
   input  game_types_pkg::rod_btn_t right_btn,
   input  game_types_pkg::pixel_t   pix,
   output game_types_pkg::rgb_t     rgb,
   output logic                     score1,
   output logic                     score2
);

   import game_types_pkg::*;

   logic   frame_tick;
   logic   serve, serve_left;
   logic   goal_right_mouth, goal_left_mouth;
   coord_t left_top, right_top;
   ball_t  ball;

   ////////////////////////////////////////
   // control
   ////////////////////////////////////////

   game_ctrl #(
      .refresh_period (refresh_period)
   ) u_ctrl (
      .clk              (clk),
      .reset            (reset),
      .stop_ball        (stop_ball),
      .goal_right_mouth (goal_right_mouth),
      .goal_left_mouth  (goal_left_mouth),
      .frame_tick       (frame_tick),
      .serve            (serve),
      .serve_left       (serve_left),
      .score1           (score1),
      .score2           (score2)
   );

   ////////////////////////////////////////
   // datapaths
   ////////////////////////////////////////

   rod_mover left_rod  (.clk(clk), .reset(reset), .frame_tick(frame_tick),
                        .btn(left_btn), .rod_top(left_top));

   rod_mover right_rod (.clk(clk), .reset(reset), .frame_tick(frame_tick),
                        .btn(right_btn), .rod_top(right_top));

   ball_mover u_ball (
      .clk              (clk),
      .reset            (reset),
      .frame_tick       (frame_tick),
      .serve            (serve),
      .serve_left       (serve_left),
      .left_top         (left_top),
      .right_top        (right_top),
      .ball             (ball),
      .goal_right_mouth (goal_right_mouth),
      .goal_left_mouth  (goal_left_mouth)
   );

   pixel_renderer u_render (
      .clk       (clk),
      .reset     (reset),
      .pix       (pix),
      .ball      (ball),
      .left_top  (left_top),
      .right_top (right_top),
      .rgb       (rgb)
   );

endmodule

/* hw/game_cfg_pkg.sv */
package game_cfg_pkg;

   ////////////////////////////////////////
   // frame rate
   ////////////////////////////////////////

   localparam int refresh_default = 830000; // clocks per frame tick minus one, 100 MHz board

   ////////////////////////////////////////
   // field geometry
   ////////////////////////////////////////

   localparam int field_bottom = 479;       // last visible row

   // goalkeeper rods, both the same size
   localparam int rod_len       = 100;      // vertical length
   localparam int rod_thick     = 10;       // horizontal thickness
   localparam int rod_step      = 10;       // pixels moved per tick
   localparam int rod_start_top = 260;
   localparam int left_rod_x    = 5;        // left edge of the left rod
   localparam int right_rod_x   = 625;      // left edge of the right rod

   // ball
   localparam int ball_start  = 300;        // centre spot, same for x and y
   localparam int ball_radius = 8;
   localparam int ball_speed  = 3;          // bounce velocity magnitude
   localparam int serve_h     = 4;          // serve velocity, x part
   localparam int serve_v     = 3;          // serve velocity, y part

   // goal mouth rows and the gap in the side walls
   localparam int goal_low      = 140;
   localparam int goal_high     = 340;
   localparam int wall_gap_low  = 200;
   localparam int wall_gap_high = 280;

   // rows where the ball turns back vertically
   localparam int top_bounce    = 20;
   localparam int bottom_bounce = 460;

   ////////////////////////////////////////
   // colours, bgr order
   ////////////////////////////////////////

   localparam logic [2:0] col_field     = 3'b010; // green
   localparam logic [2:0] col_frame     = 3'b111; // white
   localparam logic [2:0] col_left_rod  = 3'b001; // red
   localparam logic [2:0] col_right_rod = 3'b100; // blue
   localparam logic [2:0] col_ball      = 3'b111; // white
   localparam logic [2:0] col_blank     = 3'b000;

endpackage

/* hw/game_ctrl.sv */
`timescale 1ns/1ps

module game_ctrl #(
   parameter int refresh_period = game_cfg_pkg::refresh_default
) (
   input  logic clk,
   input  logic reset,
   input  logic stop_ball,        // throw level from the board switch
   input  logic goal_right_mouth, // ball went into the right goal
   input  logic goal_left_mouth,  // ball went into the left goal
   output logic frame_tick,       // one clock strobe per frame
   output logic serve,
   output logic serve_left,       // direction of the next serve
   output logic score1,
   output logic score2
);

   // counter must hold refresh_period itself
   localparam int cnt_w = (refresh_period > 0) ? $clog2(refresh_period + 1) : 1;

   logic [cnt_w-1:0] cnt;

   ////////////////////////////////////////
   // frame tick
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         cnt <= '0;
      end
      else if (cnt == cnt_w'(refresh_period))
      begin
         cnt <= '0;                       // wrap, next cycle ticks
      end
      else
      begin
         cnt <= cnt + 1'b1;
      end
   end

   assign frame_tick = (cnt == '0);       // first clock of every frame

   // the throw level goes straight to the ball
   assign serve = stop_ball;

   ////////////////////////////////////////
   // serve side and score pulses
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         serve_left <= 1'b0;              // first serve heads right
         score1     <= 1'b0;
         score2     <= 1'b0;
      end
      else
      begin
         score1 <= goal_right_mouth;      // player 1 scores on the right goal
         score2 <= goal_left_mouth;
         if (goal_right_mouth)
            serve_left <= 1'b0;           // serve away from player 1
         else if (goal_left_mouth)
            serve_left <= 1'b1;           // player 2 scored, serve toward player 1
      end
   end

endmodule

/* hw/game_types_pkg.sv */
package game_types_pkg;

   ////////////////////////////////////////
   // scalar types
   ////////////////////////////////////////

   // signed so the ball may run a little past the screen edge
   typedef logic signed [10:0] coord_t;

   typedef logic signed [3:0] vel_t;        // pixels per tick, either sign

   typedef logic [2:0] rgb_t;               // one bit per gun

   ////////////////////////////////////////
   // grouped signals
   ////////////////////////////////////////

   // push button levels of one rod
   typedef struct packed {
      logic up;
      logic down;
   } rod_btn_t;

   // pixel cursor from the vga timing block
   typedef struct packed {
      logic [9:0] x;                        // column 0..639
      logic [8:0] y;                        // row 0..479
      logic       video_on;                 // inside the visible area
   } pixel_t;

   // ball centre
   typedef struct packed {
      coord_t x;
      coord_t y;
   } ball_t;

endpackage

/* hw/pixel_renderer.sv */
`timescale 1ns/1ps

module pixel_renderer (
   input  logic                   clk,
   input  logic                   reset,
   input  game_types_pkg::pixel_t pix,
   input  game_types_pkg::ball_t  ball,
   input  game_types_pkg::coord_t left_top,
   input  game_types_pkg::coord_t right_top,
   output game_types_pkg::rgb_t   rgb
);

   import game_cfg_pkg::*;
   import game_types_pkg::*;

   localparam int frame_w     = 5;        // border thickness
   localparam int frame_low   = field_bottom - frame_w;   // 474
   localparam int frame_right = 639 - frame_w;            // 634

   coord_t px, py;                        // cursor as signed coordinates
   logic signed [12:0] dx, dy;            // wide enough for a ball off screen
   logic [25:0] dist2;

   logic on_frame, on_left, on_right, on_ball;
   logic [2:0] n_obj;                     // objects covering this pixel
   rgb_t rgb_next;

   assign px = coord_t'({1'b0, pix.x});
   assign py = coord_t'({2'b00, pix.y});

   ////////////////////////////////////////
   // object coverage
   ////////////////////////////////////////

   // top and bottom bars, side walls except the goal mouths
   assign on_frame = (py < frame_w) || (py > frame_low)
                     || ((py != 0) && ((py < goal_low) || (py > goal_high))
                         && ((px < frame_w) || (px > frame_right)));

   // rods, edges excluded
   assign on_left  = (py > left_top) && (py < left_top + rod_len)
                     && (px > left_rod_x) && (px < left_rod_x + rod_thick);
   assign on_right = (py > right_top) && (py < right_top + rod_len)
                     && (px > right_rod_x) && (px < right_rod_x + rod_thick);

   assign dx      = px - ball.x;
   assign dy      = py - ball.y;
   assign dist2   = dx * dx + dy * dy;
   assign on_ball = (dist2 <= ball_radius * ball_radius);   // round ball

   assign n_obj = 3'(on_frame) + 3'(on_left) + 3'(on_right) + 3'(on_ball);

   ////////////////////////////////////////
   // colour select
   ////////////////////////////////////////

   always_comb
   begin
      if (!pix.video_on)
         rgb_next = col_blank;            // blanking interval
      else if (n_obj == 3'd0)
         rgb_next = col_field;
      else if (n_obj != 3'd1)
         rgb_next = col_blank;            // overlap shows black
      else if (on_frame)
         rgb_next = col_frame;
      else if (on_left)
         rgb_next = col_left_rod;
      else if (on_right)
         rgb_next = col_right_rod;
      else
         rgb_next = col_ball;
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         rgb <= col_blank;
      else
         rgb <= rgb_next;                 // one clock behind the cursor
   end

endmodule

/* hw/rod_mover.sv */
`timescale 1ns/1ps

module rod_mover (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     frame_tick,
   input  game_types_pkg::rod_btn_t btn,
   output game_types_pkg::coord_t   rod_top
);

   import game_cfg_pkg::*;

   // lowest top that still lets the rod take one more step down
   localparam int down_limit = field_bottom - rod_step - rod_len;

   logic can_up;
   logic can_down;

   assign can_up   = btn.up && (rod_top > rod_step);
   assign can_down = btn.down && (rod_top < down_limit);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         rod_top <= 11'(rod_start_top);
      end
      else if (frame_tick)
      begin
         if (can_up)                      // up wins when both are held
            rod_top <= rod_top - 11'(rod_step);
         else if (can_down)
            rod_top <= rod_top + 11'(rod_step);
         // otherwise hold
      end
   end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the foosball testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
   --top-module foosball_tb \
   -f foosball.f \
   -o foosball_sim

./obj_dir/foosball_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
   echo "simulation failed"
   exit 1
fi

echo "simulation passed"
